// File: verilog.f
+incdir+include
hdl/lsu_pkg.sv
hdl/dmem_if.sv
hdl/ex_mem_reg.sv
hdl/mem_access_stage.sv
hdl/data_ram.sv
hdl/clint_timer.sv
hdl/mem_wb_reg.sv
hdl/lsu_top.sv
bench/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - include_dirs:
      - include
    files:
      - hdl/lsu_pkg.sv
      - hdl/dmem_if.sv
      - hdl/ex_mem_reg.sv
      - hdl/mem_access_stage.sv
      - hdl/data_ram.sv
      - hdl/clint_timer.sv
      - hdl/mem_wb_reg.sv
      - hdl/lsu_top.sv
      - target: test
        include_dirs:
          - include
        files:
          - bench/lsu_tb.sv

// File: bench/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module lsu_tb;

  localparam int MODEL_BYTES = 512;  // low 64 RAM words
  localparam int N_RAND      = 400;
  localparam int N_PASS      = 32;
  localparam int N_MIS       = 40;
  localparam int TOTAL_INSTR = MODEL_BYTES / 8 + N_RAND + N_PASS + 2 * N_MIS + 8;
  localparam int TIMEOUT_NS  = TOTAL_INSTR * 4 * 8 + 1000;

  logic              clk_i;
  logic              arst_n_i;
  logic              ex_valid_i;
  lsu_pkg::memop_e   ex_op_i;
  lsu_pkg::xlen_t    ex_alu_i;
  lsu_pkg::xlen_t    ex_rs2_i;
  lsu_pkg::reg_idx_t ex_rd_i;
  lsu_pkg::trap_t    ex_trap_i;
  logic              ex_ready_o;
  logic              wb_valid_o;
  lsu_pkg::reg_idx_t wb_rd_o;
  lsu_pkg::xlen_t    wb_result_o;
  lsu_pkg::trap_t    wb_trap_o;
  logic              timer_irq_o;

  logic [7:0]     mem_model [MODEL_BYTES];
  lsu_pkg::xlen_t model_cmp = '0;

  // expected writebacks, oldest first
  lsu_pkg::reg_idx_t exp_rd_q[$];
  lsu_pkg::xlen_t    exp_res_q[$];
  lsu_pkg::trap_t    exp_trap_q[$];
  logic              exp_chk_q[$];
  lsu_pkg::xlen_t    got_q[$];  // mtime reads, no fixed value
  int                wb_cyc_q[$];

  int error_count = 0;
  int wb_checked  = 0;
  int ram_ops     = 0;
  int ready_lows  = 0;
  int low_run     = 0;
  int cyc         = 0;

  lsu_top uut (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .ex_valid_i(ex_valid_i), .ex_op_i(ex_op_i), .ex_alu_i(ex_alu_i),
    .ex_rs2_i(ex_rs2_i), .ex_rd_i(ex_rd_i), .ex_trap_i(ex_trap_i),
    .ex_ready_o(ex_ready_o), .wb_valid_o(wb_valid_o), .wb_rd_o(wb_rd_o),
    .wb_result_o(wb_result_o), .wb_trap_o(wb_trap_o), .timer_irq_o(timer_irq_o)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  function automatic int op_bytes(lsu_pkg::memop_e op);
    case (op)
      lsu_pkg::memop_lb, lsu_pkg::memop_lbu, lsu_pkg::memop_sb: return 1;
      lsu_pkg::memop_lh, lsu_pkg::memop_lhu, lsu_pkg::memop_sh: return 2;
      lsu_pkg::memop_lw, lsu_pkg::memop_lwu, lsu_pkg::memop_sw: return 4;
      lsu_pkg::memop_ld, lsu_pkg::memop_sd: return 8;
      default: return 0;
    endcase
  endfunction

  function automatic logic is_store_op(lsu_pkg::memop_e op);
    return op inside {lsu_pkg::memop_sb, lsu_pkg::memop_sh, lsu_pkg::memop_sw,
                      lsu_pkg::memop_sd};
  endfunction

  // little-endian read of the model bytes, then extension
  function automatic lsu_pkg::xlen_t model_load(lsu_pkg::memop_e op, int a);
    lsu_pkg::xlen_t v;
    int n;
    n = op_bytes(op);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[8*i +: 8] = mem_model[a + i];
    end
    if ((op inside {lsu_pkg::memop_lb, lsu_pkg::memop_lh, lsu_pkg::memop_lw}) && v[8*n-1]) begin
      for (int i = 8 * n; i < `LSU_XLEN; i++) begin
        v[i] = 1'b1;
      end
    end
    return v;
  endfunction

  task automatic issue(input lsu_pkg::memop_e op, input lsu_pkg::xlen_t alu,
                       input lsu_pkg::xlen_t rs2, input lsu_pkg::trap_t trap);
    lsu_pkg::reg_idx_t rd;
    lsu_pkg::xlen_t res;
    lsu_pkg::trap_t tr;
    logic st, ld, mis, tmr, chk;
    int n, a;
    rd  = 5'($urandom_range(0, 31));
    n   = op_bytes(op);
    st  = is_store_op(op);
    ld  = (n != 0) && !st;
    a   = int'(alu[31:0]);
    mis = (n > 1) && ((a % n) != 0);
    tmr = (alu[31:0] == `LSU_MTIME_ADDR) || (alu[31:0] == `LSU_MTIMECMP_ADDR);
    chk = 1'b1;
    res = '0;
    tr  = trap;
    tr[`LSU_TRAP_LOAD_MISALIGNED]  = ld && mis;
    tr[`LSU_TRAP_STORE_MISALIGNED] = st && mis;
    if (n == 0) begin
      res = alu;
    end else if (!mis && tmr) begin
      // timer accesses here are all doubleword
      if (alu[31:0] == `LSU_MTIMECMP_ADDR) begin
        if (st) begin
          model_cmp = rs2;
        end else begin
          res = model_cmp;
        end
      end else if (ld) begin
        chk = 1'b0;  // mtime keeps ticking
      end
    end else if (!mis) begin
      ram_ops++;
      if (st) begin
        for (int i = 0; i < n; i++) begin
          mem_model[a + i] = rs2[8*i +: 8];
        end
      end else begin
        res = model_load(op, a);
      end
    end
    exp_rd_q.push_back(rd);
    exp_res_q.push_back(res);
    exp_trap_q.push_back(tr);
    exp_chk_q.push_back(chk);
    @(posedge clk_i);
    ex_valid_i <= 1'b1;
    ex_op_i    <= op;
    ex_alu_i   <= alu;
    ex_rs2_i   <= rs2;
    ex_rd_i    <= rd;
    ex_trap_i  <= trap;
    // taken at the first rising edge that sees ready high
    @(negedge clk_i);
    while (!ex_ready_o) begin
      @(negedge clk_i);
    end
  endtask

  task automatic drain();
    @(posedge clk_i);
    ex_valid_i <= 1'b0;
    while (exp_rd_q.size() != 0) begin
      @(posedge clk_i);
    end
  endtask

  task automatic close_test(input string name, input int errs_before);
    $display("test %-12s finished with %0d errors", name, error_count - errs_before);
  endtask

  // writeback and ready monitor, sampled mid-cycle
  always @(negedge clk_i) begin
    lsu_pkg::reg_idx_t e_rd;
    lsu_pkg::xlen_t e_res;
    lsu_pkg::trap_t e_trap;
    logic e_chk;
    cyc++;
    if (arst_n_i) begin
      if (!ex_ready_o) begin
        low_run++;
        ready_lows++;
        if (low_run > 1) begin
          $display("[ERROR] %0t: ex_ready_o low for %0d cycles in a row", $time, low_run);
          error_count++;
        end
      end else begin
        low_run = 0;
      end
      if (wb_valid_o) begin
        wb_cyc_q.push_back(cyc);
        if (exp_rd_q.size() == 0) begin
          $display("a writeback came out with no instruction waiting for it (rd %0d)", wb_rd_o);
          error_count++;
        end else begin
          e_rd   = exp_rd_q.pop_front();
          e_res  = exp_res_q.pop_front();
          e_trap = exp_trap_q.pop_front();
          e_chk  = exp_chk_q.pop_front();
          wb_checked++;
          if (wb_rd_o !== e_rd) begin
            $display("[ERROR] %0t: rd %0d, expected %0d", $time, wb_rd_o, e_rd);
            error_count++;
          end
          if (wb_trap_o !== e_trap) begin
            $display("[ERROR] %0t: trap %b, expected %b", $time, wb_trap_o, e_trap);
            error_count++;
          end
          if (e_chk && (wb_result_o !== e_res)) begin
            $display("[ERROR] %0t: result %h, expected %h", $time, wb_result_o, e_res);
            error_count++;
          end
          if (!e_chk) begin
            got_q.push_back(wb_result_o);
          end
        end
      end
    end
  end

  initial begin
    lsu_pkg::memop_e op;
    lsu_pkg::xlen_t first_t, second_t, cmp_val;
    int errs, n, w, off;
    logic irq_seen;
    void'($urandom(32'h7fc4));
    arst_n_i   = 1'b0;
    ex_valid_i = 1'b0;
    ex_op_i    = lsu_pkg::memop_none;
    ex_alu_i   = '0;
    ex_rs2_i   = '0;
    ex_rd_i    = '0;
    ex_trap_i  = '0;
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;

    // flops have not clocked since reset went away
    errs = error_count;
    @(negedge clk_i);
    if (wb_valid_o !== 1'b0 || timer_irq_o !== 1'b0 || ex_ready_o !== 1'b1) begin
      $display("[ERROR] %0t: after reset wb_valid %b, irq %b, ready %b", $time,
               wb_valid_o, timer_irq_o, ex_ready_o);
      error_count++;
    end
    close_test("reset", errs);

    errs = error_count;
    ram_ops    = 0;
    ready_lows = 0;
    for (int i = 0; i < MODEL_BYTES / 8; i++) begin
      issue(lsu_pkg::memop_sd, i * 8, {$urandom, $urandom}, '0);  // fill the window
    end
    for (int i = 0; i < N_RAND; i++) begin
      op = lsu_pkg::memop_e'($urandom_range(0, 11));
      n  = op_bytes(op);
      if (n == 0) begin
        issue(op, {$urandom, $urandom}, {$urandom, $urandom}, 8'($urandom));
      end else begin
        w   = $urandom_range(0, MODEL_BYTES / 8 - 1);
        off = $urandom_range(0, 7) & ~(n - 1);
        issue(op, w * 8 + off, {$urandom, $urandom}, 8'($urandom));
      end
    end
    drain();
    if (ready_lows != ram_ops) begin
      $display("[ERROR] %0t: ex_ready_o low %0d cycles for %0d RAM accesses", $time,
               ready_lows, ram_ops);
      error_count++;
    end
    close_test("aligned_mem", errs);

    errs = error_count;
    wb_cyc_q.delete();
    for (int i = 0; i < N_PASS; i++) begin
      issue(lsu_pkg::memop_none, {$urandom, $urandom}, '0, 8'($urandom));
    end
    drain();
    if (wb_cyc_q.size() != N_PASS) begin
      $display("pass-through ops wrote back %0d times instead of %0d", wb_cyc_q.size(), N_PASS);
      error_count++;
    end
    for (int i = 1; i < wb_cyc_q.size(); i++) begin
      if (wb_cyc_q[i] != wb_cyc_q[i-1] + 1) begin
        $display("[ERROR] %0t: writeback gap before pass-through op %0d", $time, i);
        error_count++;
      end
    end
    close_test("pass_thru", errs);

    errs = error_count;
    for (int i = 0; i < N_MIS; i++) begin
      do begin
        op = lsu_pkg::memop_e'($urandom_range(3, 11));
      end while (op == lsu_pkg::memop_sb);
      n = op_bytes(op);
      w = $urandom_range(0, MODEL_BYTES / 8 - 1);
      do begin
        off = $urandom_range(1, 7);
      end while ((off % n) == 0);
      issue(op, w * 8 + off, {$urandom, $urandom}, 8'($urandom));
      issue(lsu_pkg::memop_ld, w * 8, '0, '0);  // word must be untouched
    end
    drain();
    close_test("misaligned", errs);

    errs = error_count;
    got_q.delete();
    cmp_val = {1'b1, $urandom, 31'($urandom)};  // far beyond mtime
    issue(lsu_pkg::memop_sd, `LSU_MTIMECMP_ADDR, cmp_val, '0);
    issue(lsu_pkg::memop_ld, `LSU_MTIMECMP_ADDR, '0, '0);
    issue(lsu_pkg::memop_ld, `LSU_MTIME_ADDR, '0, '0);
    issue(lsu_pkg::memop_ld, `LSU_MTIME_ADDR, '0, '0);
    drain();
    if (got_q.size() != 2) begin
      $display("expected two mtime reads to write back, saw %0d", got_q.size());
      error_count++;
    end else begin
      first_t  = got_q.pop_front();
      second_t = got_q.pop_front();
      if (second_t <= first_t) begin
        $display("[ERROR] %0t: mtime %0d then %0d, not increasing", $time, first_t, second_t);
        error_count++;
      end
    end
    @(negedge clk_i);
    if (timer_irq_o !== 1'b0) begin
      $display("[ERROR] %0t: timer_irq_o high with mtimecmp far ahead", $time);
      error_count++;
    end
    issue(lsu_pkg::memop_sd, `LSU_MTIMECMP_ADDR, '0, '0);
    drain();
    irq_seen = 1'b0;
    repeat (2) begin
      @(negedge clk_i);
      if (timer_irq_o === 1'b1) begin
        irq_seen = 1'b1;
      end
    end
    if (!irq_seen) begin
      $display("[ERROR] %0t: timer_irq_o not raised with mtimecmp at zero", $time);
      error_count++;
    end
    issue(lsu_pkg::memop_sd, `LSU_MTIMECMP_ADDR, '1, '0);
    issue(lsu_pkg::memop_sd, `LSU_MTIME_ADDR, '0, '0);
    drain();
    repeat (4) begin
      @(negedge clk_i);
      if (timer_irq_o !== 1'b0) begin
        $display("[ERROR] %0t: timer_irq_o high with mtimecmp all ones", $time);
        error_count++;
      end
    end
    close_test("timer", errs);

    $display("5 tests, %0d writebacks checked, %0d errors", wb_checked, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // watchdog, scaled to the instruction count
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              ex_valid_i,
  input  lsu_pkg::memop_e   ex_op_i,
  input  lsu_pkg::xlen_t    ex_alu_i,
  input  lsu_pkg::xlen_t    ex_rs2_i,
  input  lsu_pkg::reg_idx_t ex_rd_i,
  input  lsu_pkg::trap_t    ex_trap_i,
  output logic              ex_ready_o,
  output logic              wb_valid_o,
  output lsu_pkg::reg_idx_t wb_rd_o,
  output lsu_pkg::xlen_t    wb_result_o,
  output lsu_pkg::trap_t    wb_trap_o,
  output logic              timer_irq_o
);

  logic              stall;
  logic              m_valid, s_valid;
  lsu_pkg::memop_e   m_op;
  lsu_pkg::xlen_t    m_alu, m_rs2, s_result;
  lsu_pkg::reg_idx_t m_rd, s_rd;
  lsu_pkg::trap_t    m_trap, s_trap;
  lsu_pkg::addr_t    tmr_addr;
  logic              tmr_sel, tmr_we;
  lsu_pkg::xlen_t    tmr_wdata, tmr_rdata;

  dmem_if dmem_bus (.clk_i(clk_i), .arst_n_i(arst_n_i));

  ex_mem_reg u_ex_mem (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .valid_i(ex_valid_i), .op_i(ex_op_i), .alu_i(ex_alu_i), .rs2_i(ex_rs2_i),
    .rd_i(ex_rd_i), .trap_i(ex_trap_i), .stall_i(stall),
    .valid_o(m_valid), .op_o(m_op), .alu_o(m_alu), .rs2_o(m_rs2),
    .rd_o(m_rd), .trap_o(m_trap)
  );

  mem_access_stage u_mem (
    .valid_i(m_valid), .op_i(m_op), .alu_i(m_alu), .rs2_i(m_rs2),
    .rd_i(m_rd), .trap_i(m_trap), .dmem(dmem_bus.stage),
    .tmr_addr_o(tmr_addr), .tmr_sel_o(tmr_sel), .tmr_we_o(tmr_we),
    .tmr_wdata_o(tmr_wdata), .tmr_rdata_i(tmr_rdata),
    .stall_o(stall), .valid_o(s_valid), .rd_o(s_rd),
    .result_o(s_result), .trap_o(s_trap)
  );

  data_ram u_ram (.clk_i(clk_i), .arst_n_i(arst_n_i), .dmem(dmem_bus.mem));

  clint_timer u_clint (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .addr_i(tmr_addr), .sel_i(tmr_sel), .we_i(tmr_we), .wdata_i(tmr_wdata),
    .rdata_o(tmr_rdata), .timer_irq_o(timer_irq_o)
  );

  mem_wb_reg u_mem_wb (
    .clk_i(clk_i), .arst_n_i(arst_n_i),
    .valid_i(s_valid), .rd_i(s_rd), .result_i(s_result), .trap_i(s_trap),
    .stall_i(stall),
    .valid_o(wb_valid_o), .rd_o(wb_rd_o), .result_o(wb_result_o), .trap_o(wb_trap_o)
  );

  assign ex_ready_o = ~stall;  // whole front waits on the RAM

endmodule

`default_nettype wire

// File: hdl/mem_wb_reg.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_reg (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              valid_i,
  input  lsu_pkg::reg_idx_t rd_i,
  input  lsu_pkg::xlen_t    result_i,
  input  lsu_pkg::trap_t    trap_i,
  input  logic              stall_i,
  output logic              valid_o,
  output lsu_pkg::reg_idx_t rd_o,
  output lsu_pkg::xlen_t    result_o,
  output lsu_pkg::trap_t    trap_o
);

  // bubble while the memory stage waits on the RAM
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i & ~stall_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      rd_o     <= rd_i;
      result_o <= result_i;
      trap_o   <= trap_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module clint_timer (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  lsu_pkg::addr_t addr_i,
  input  logic           sel_i,
  input  logic           we_i,
  input  lsu_pkg::xlen_t wdata_i,
  output lsu_pkg::xlen_t rdata_o,
  output logic           timer_irq_o
);

  lsu_pkg::xlen_t mtime_q, mtimecmp_q;
  logic is_mtime, is_cmp;
  logic irq_q;

  assign is_mtime = (addr_i == `LSU_MTIME_ADDR);
  assign is_cmp   = (addr_i == `LSU_MTIMECMP_ADDR);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '0;
      irq_q      <= 1'b0;
    end else begin
      if (sel_i && we_i && is_mtime) begin
        mtime_q <= wdata_i;  // a write wins over the tick
      end else begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (sel_i && we_i && is_cmp) begin
        mtimecmp_q <= wdata_i;
      end
      irq_q <= (mtime_q >= mtimecmp_q);
    end
  end

  // anything not mtimecmp reads as mtime
  assign rdata_o = is_cmp ? mtimecmp_q : mtime_q;

  assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module data_ram #(
  parameter int WORDS = `LSU_DMEM_WORDS
) (
  input logic clk_i,
  input logic arst_n_i,
  dmem_if.mem dmem
);

  localparam int IDX_W = $clog2(WORDS);
  localparam int NBYTES = `LSU_XLEN / 8;

  lsu_pkg::xlen_t mem_q [WORDS];
  logic [IDX_W-1:0] idx;
  logic ready_q;
  lsu_pkg::xlen_t rdata_q;

  assign idx = dmem.addr[IDX_W+2:3];  // word index, byte offset dropped

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= dmem.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dmem.req) begin
      rdata_q <= mem_q[idx];  // full word, stage picks the bytes
      if (dmem.we) begin
        for (int b = 0; b < NBYTES; b++) begin
          if (dmem.mask[b]) begin
            mem_q[idx][8*b +: 8] <= dmem.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  assign dmem.ready = ready_q;
  assign dmem.rdata = rdata_q;

  // stage must drop req on ready, otherwise the access repeats
  a_ready_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dmem.ready |=> !dmem.ready);

  // size read as a number is the byte count
  a_mask_size: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dmem.req |-> ($countones(dmem.mask) == int'(dmem.size)));

endmodule

`default_nettype wire

// File: hdl/mem_access_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

module mem_access_stage (
  input  logic              valid_i,
  input  lsu_pkg::memop_e   op_i,
  input  lsu_pkg::xlen_t    alu_i,
  input  lsu_pkg::xlen_t    rs2_i,
  input  lsu_pkg::reg_idx_t rd_i,
  input  lsu_pkg::trap_t    trap_i,
  dmem_if.stage             dmem,
  output lsu_pkg::addr_t    tmr_addr_o,
  output logic              tmr_sel_o,
  output logic              tmr_we_o,
  output lsu_pkg::xlen_t    tmr_wdata_o,
  input  lsu_pkg::xlen_t    tmr_rdata_i,
  output logic              stall_o,
  output logic              valid_o,
  output lsu_pkg::reg_idx_t rd_o,
  output lsu_pkg::xlen_t    result_o,
  output lsu_pkg::trap_t    trap_o
);

  logic op_none, is_load, is_store, is_signed;
  logic sz1, sz2, sz4, sz8;
  logic misaligned, hit_tmr, acc_ok, ram_acc;
  lsu_pkg::addr_t addr;
  logic [2:0] off;
  logic [`LSU_XLEN/8-1:0] mask_base;
  lsu_pkg::xlen_t wdata_base, rsrc, ld_ext;

  // opcode decode
  assign op_none   = (op_i == lsu_pkg::memop_none);
  assign is_load   = (op_i == lsu_pkg::memop_lb) | (op_i == lsu_pkg::memop_lbu) |
                     (op_i == lsu_pkg::memop_lh) | (op_i == lsu_pkg::memop_lhu) |
                     (op_i == lsu_pkg::memop_lw) | (op_i == lsu_pkg::memop_lwu) |
                     (op_i == lsu_pkg::memop_ld);
  assign is_store  = (op_i == lsu_pkg::memop_sb) | (op_i == lsu_pkg::memop_sh) |
                     (op_i == lsu_pkg::memop_sw) | (op_i == lsu_pkg::memop_sd);
  assign is_signed = (op_i == lsu_pkg::memop_lb) | (op_i == lsu_pkg::memop_lh) |
                     (op_i == lsu_pkg::memop_lw) | (op_i == lsu_pkg::memop_ld);

  assign sz1 = (op_i == lsu_pkg::memop_lb) | (op_i == lsu_pkg::memop_lbu) |
               (op_i == lsu_pkg::memop_sb);
  assign sz2 = (op_i == lsu_pkg::memop_lh) | (op_i == lsu_pkg::memop_lhu) |
               (op_i == lsu_pkg::memop_sh);
  assign sz4 = (op_i == lsu_pkg::memop_lw) | (op_i == lsu_pkg::memop_lwu) |
               (op_i == lsu_pkg::memop_sw);
  assign sz8 = (op_i == lsu_pkg::memop_ld) | (op_i == lsu_pkg::memop_sd);

  assign addr = alu_i[31:0];
  assign off  = addr[2:0];

  assign mask_base = ({8{sz1}} & 8'b0000_0001) | ({8{sz2}} & 8'b0000_0011) |
                     ({8{sz4}} & 8'b0000_1111) | ({8{sz8}} & 8'b1111_1111);

  // store data trimmed to the access size, still at the low end
  assign wdata_base = ({`LSU_XLEN{sz1}} & {{(`LSU_XLEN-8){1'b0}}, rs2_i[7:0]}) |
                      ({`LSU_XLEN{sz2}} & {{(`LSU_XLEN-16){1'b0}}, rs2_i[15:0]}) |
                      ({`LSU_XLEN{sz4}} & {{(`LSU_XLEN-32){1'b0}}, rs2_i[31:0]}) |
                      ({`LSU_XLEN{sz8}} & rs2_i);

  // byte accesses can never be misaligned
  assign misaligned = (sz2 & addr[0]) | (sz4 & (|addr[1:0])) | (sz8 & (|addr[2:0]));

  // target select
  assign hit_tmr = (addr == `LSU_MTIME_ADDR) | (addr == `LSU_MTIMECMP_ADDR);
  assign acc_ok  = valid_i & (is_load | is_store) & ~misaligned;
  assign ram_acc = acc_ok & ~hit_tmr;

  assign tmr_addr_o  = addr;
  assign tmr_sel_o   = acc_ok & hit_tmr;
  assign tmr_we_o    = is_store;
  assign tmr_wdata_o = wdata_base;  // timer regs are 8-byte aligned

  // drop req in the ready cycle so the access is issued once
  assign dmem.req   = ram_acc & ~dmem.ready;
  assign dmem.we    = is_store;
  assign dmem.addr  = addr;
  assign dmem.size  = {sz8, sz4, sz2, sz1};
  assign dmem.mask  = is_store ? (mask_base << off) : mask_base;
  assign dmem.wdata = wdata_base << {off, 3'b000};

  assign stall_o = dmem.req;

  // RAM hands back the whole word, bring the addressed bytes down
  assign rsrc = tmr_sel_o ? tmr_rdata_i : (dmem.rdata >> {off, 3'b000});

  assign ld_ext =
    ({`LSU_XLEN{sz1}} & {{(`LSU_XLEN-8){is_signed & rsrc[7]}}, rsrc[7:0]}) |
    ({`LSU_XLEN{sz2}} & {{(`LSU_XLEN-16){is_signed & rsrc[15]}}, rsrc[15:0]}) |
    ({`LSU_XLEN{sz4}} & {{(`LSU_XLEN-32){is_signed & rsrc[31]}}, rsrc[31:0]}) |
    ({`LSU_XLEN{sz8}} & rsrc);

  // stores and faulting loads write back zero
  assign result_o = ({`LSU_XLEN{op_none}} & alu_i) |
                    ({`LSU_XLEN{is_load & ~misaligned}} & ld_ext);

  always_comb begin
    trap_o = trap_i;
    trap_o[`LSU_TRAP_LOAD_MISALIGNED]  = is_load & misaligned;
    trap_o[`LSU_TRAP_STORE_MISALIGNED] = is_store & misaligned;
  end

  assign valid_o = valid_i;
  assign rd_o    = rd_i;

  // a pending RAM request keeps its address and never turns into a timer access
  a_no_tmr_req: assert property (@(posedge dmem.clk_i) disable iff (!dmem.arst_n_i)
    dmem.req |=> !tmr_sel_o && $stable(dmem.addr));

  a_req_mask: assert property (@(posedge dmem.clk_i) disable iff (!dmem.arst_n_i)
    dmem.req |-> (|dmem.mask));

endmodule

`default_nettype wire

// File: hdl/ex_mem_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg (
  input  logic              clk_i,
  input  logic              arst_n_i,
  input  logic              valid_i,
  input  lsu_pkg::memop_e   op_i,
  input  lsu_pkg::xlen_t    alu_i,
  input  lsu_pkg::xlen_t    rs2_i,
  input  lsu_pkg::reg_idx_t rd_i,
  input  lsu_pkg::trap_t    trap_i,
  input  logic              stall_i,
  output logic              valid_o,
  output lsu_pkg::memop_e   op_o,
  output lsu_pkg::xlen_t    alu_o,
  output lsu_pkg::xlen_t    rs2_o,
  output lsu_pkg::reg_idx_t rd_o,
  output lsu_pkg::trap_t    trap_o
);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else if (!stall_i) begin
      valid_o <= valid_i;
    end
  end

  // instruction fields, frozen while memory stalls
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      op_o   <= op_i;
      alu_o  <= alu_i;
      rs2_o  <= rs2_i;
      rd_o   <= rd_i;
      trap_o <= trap_i;
    end
  end

  // a stalled access must see the same request until the RAM answers
  a_hold_on_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    stall_i |=> $stable({valid_o, op_o, alu_o, rs2_o, rd_o, trap_o}));

endmodule

`default_nettype wire

// File: hdl/dmem_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "lsu_defs.svh"

interface dmem_if (
  input logic clk_i,
  input logic arst_n_i
);

  lsu_pkg::addr_t          addr;
  logic                    req;    // held until ready
  logic                    we;
  logic [`LSU_XLEN/8-1:0]  mask;   // byte strobes
  logic [3:0]              size;   // one-hot byte count
  lsu_pkg::xlen_t          wdata;
  logic                    ready;  // single-cycle pulse
  lsu_pkg::xlen_t          rdata;

  modport stage (
    input  clk_i, arst_n_i, ready, rdata,
    output addr, req, we, mask, size, wdata
  );

  modport mem (
    input  addr, req, we, mask, size, wdata,
    output ready, rdata
  );

endinterface

`default_nettype wire

// File: hdl/lsu_pkg.sv
`default_nettype none

`include "lsu_defs.svh"

package lsu_pkg;

  // one register-wide data word
  typedef logic [`LSU_XLEN-1:0] xlen_t;

  // byte address, only the low 32 bits are decoded
  typedef logic [31:0] addr_t;

  typedef logic [4:0] reg_idx_t;  // rd index

  // one bit per trap cause
  typedef logic [`LSU_TRAP_LEN-1:0] trap_t;

  // memory opcode handed down from execute
  typedef enum logic [3:0] {
    memop_none = 4'd0,
    memop_lb   = 4'd1,
    memop_lbu  = 4'd2,
    memop_lh   = 4'd3,
    memop_lhu  = 4'd4,
    memop_lw   = 4'd5,
    memop_lwu  = 4'd6,
    memop_ld   = 4'd7,
    memop_sb   = 4'd8,
    memop_sh   = 4'd9,
    memop_sw   = 4'd10,
    memop_sd   = 4'd11
  } memop_e;

endpackage

`default_nettype wire

// File: include/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// data path width in bits
`define LSU_XLEN 64

// core-local timer registers, byte addresses
`define LSU_MTIME_ADDR    32'h0200_BFF8
`define LSU_MTIMECMP_ADDR 32'h0200_4000

// trap vector layout
`define LSU_TRAP_LEN              8
`define LSU_TRAP_LOAD_MISALIGNED  4
`define LSU_TRAP_STORE_MISALIGNED 6

// data RAM depth in 64-bit words
`define LSU_DMEM_WORDS 256

`endif
